// File: source/lsu_pkg.sv
/*
 * Shared types and encodings for the RV64 load/store subsystem.
 * Imported by the ports, the data path blocks and the RAM.
 */

package lsu_pkg;

    // Data path widths.
    typedef logic [63:0] data_t;    // Register value, RAM word, Wishbone data.
    typedef logic [7:0]  sel_t;     // Wishbone byte selects.
    typedef logic [2:0]  func3_t;   // RISC-V funct3 of a load or store.
    typedef logic [2:0]  offset_t;  // Byte offset within a 64-bit word.

    // --------------------------------------------------
    // Load funct3 codes. Stores reuse codes 0 to 3.
    // --------------------------------------------------
    localparam func3_t F3_LB  = 3'd0;
    localparam func3_t F3_LH  = 3'd1;
    localparam func3_t F3_LW  = 3'd2;
    localparam func3_t F3_LD  = 3'd3;
    localparam func3_t F3_LBU = 3'd4;
    localparam func3_t F3_LHU = 3'd5;
    localparam func3_t F3_LWU = 3'd6;

    // Request port states.
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_RESP
    } lsu_state_e;

endpackage

// File: source/load_mux.sv
/*
 * Load data extraction for RV64 loads. Picks the addressed lane from a
 * 64-bit memory word and sign or zero extends it by funct3.
 */

`timescale 1ns/1ns

module load_mux (
    // Control.
    input  lsu_pkg::func3_t  i_func_3,

    // Memory word and byte offset.
    input  lsu_pkg::data_t   i_data,
    input  lsu_pkg::offset_t i_addr_offset,

    // Extended result and flags.
    output lsu_pkg::data_t   o_data,
    output logic             o_load_addr_ma,
    output logic             o_illegal_instr
);
    import lsu_pkg::*;

    logic [7:0]  s_byte;
    logic [15:0] s_half;
    logic [31:0] s_word;

    logic s_ma_half;
    logic s_ma_word;
    logic s_ma_double;

    // Lane select across the whole 64-bit word.
    assign s_byte = i_data[{i_addr_offset, 3'b000} +: 8];
    assign s_half = i_data[{i_addr_offset[2:1], 4'b0000} +: 16];
    assign s_word = i_data[{i_addr_offset[2], 5'b00000} +: 32];

    assign s_ma_half   = i_addr_offset[0];
    assign s_ma_word   = |i_addr_offset[1:0];
    assign s_ma_double = |i_addr_offset;

    always_comb begin
        o_illegal_instr = 1'b0;
        o_load_addr_ma  = 1'b0;

        case (i_func_3)
            F3_LB:  o_data = {{56{s_byte[7]}}, s_byte};
            F3_LH: begin
                o_data         = {{48{s_half[15]}}, s_half};
                o_load_addr_ma = s_ma_half;
            end
            F3_LW: begin
                o_data         = {{32{s_word[31]}}, s_word};
                o_load_addr_ma = s_ma_word;
            end
            F3_LD: begin
                o_data         = i_data;
                o_load_addr_ma = s_ma_double;
            end
            F3_LBU: o_data = {56'd0, s_byte};
            F3_LHU: begin
                o_data         = {48'd0, s_half};
                o_load_addr_ma = s_ma_half;
            end
            F3_LWU: begin
                o_data         = {32'd0, s_word};
                o_load_addr_ma = s_ma_word;
            end
            default: begin
                o_data          = '0;  // Code 7 has no load.
                o_illegal_instr = 1'b1;
            end
        endcase
    end

endmodule

// File: source/store_merge.sv
/*
 * Store lane placement for SB/SH/SW/SD. Builds Wishbone byte selects
 * and write data replicated into the addressed lane.
 */

`timescale 1ns/1ns

module store_merge (
    input  lsu_pkg::func3_t  i_func_3,
    input  lsu_pkg::data_t   i_wdata,
    input  lsu_pkg::offset_t i_addr_offset,

    output lsu_pkg::sel_t    o_sel,
    output lsu_pkg::data_t   o_wdata,
    output logic             o_store_addr_ma,
    output logic             o_illegal_instr
);
    import lsu_pkg::*;

    always_comb begin
        o_illegal_instr = 1'b0;

        case (i_func_3)
            F3_LB: begin
                o_sel           = sel_t'(8'b0000_0001 << i_addr_offset);
                o_wdata         = {8{i_wdata[7:0]}};
                o_store_addr_ma = 1'b0;
            end
            F3_LH: begin
                o_sel           = sel_t'(8'b0000_0011 << {i_addr_offset[2:1], 1'b0});
                o_wdata         = {4{i_wdata[15:0]}};
                o_store_addr_ma = i_addr_offset[0];
            end
            F3_LW: begin
                o_sel           = sel_t'(8'b0000_1111 << {i_addr_offset[2], 2'b00});
                o_wdata         = {2{i_wdata[31:0]}};
                o_store_addr_ma = |i_addr_offset[1:0];
            end
            F3_LD: begin
                o_sel           = 8'hff;
                o_wdata         = i_wdata;
                o_store_addr_ma = |i_addr_offset;
            end
            default: begin
                o_sel           = '0;  // Codes 4 to 7 are not stores.
                o_wdata         = '0;
                o_store_addr_ma = 1'b0;
                o_illegal_instr = 1'b1;
            end
        endcase
    end

endmodule

// File: source/lsu_port.sv
/*
 * One load/store requester. Accepts a request, faults it at once or
 * runs a single Wishbone classic cycle, then pulses the response.
 */

`timescale 1ns/1ns

module lsu_port #(
    parameter int ADDR_WIDTH = 11
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // Request.
    input  logic                  i_req_valid,
    output logic                  o_req_ready,
    input  logic                  i_req_we,
    input  lsu_pkg::func3_t       i_req_func3,
    input  logic [ADDR_WIDTH-1:0] i_req_addr,
    input  lsu_pkg::data_t        i_req_wdata,

    // Response.
    output logic                  o_rsp_valid,
    output lsu_pkg::data_t        o_rsp_rdata,
    output logic                  o_rsp_misaligned,
    output logic                  o_rsp_illegal,

    // Wishbone master.
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output logic                  o_wb_we,
    output logic [ADDR_WIDTH-4:0] o_wb_adr,
    output lsu_pkg::sel_t         o_wb_sel,
    output lsu_pkg::data_t        o_wb_dat,
    input  logic                  i_wb_ack,
    input  lsu_pkg::data_t        i_wb_dat
);
    import lsu_pkg::*;

    lsu_state_e            r_state;
    logic                  r_we;
    func3_t                r_func3;
    offset_t               r_offset;
    logic [ADDR_WIDTH-4:0] r_adr;
    sel_t                  r_sel;
    data_t                 r_wdata;
    data_t                 r_rdata;
    logic                  r_misaligned;
    logic                  r_illegal;

    func3_t  s_func3;
    offset_t s_offset;
    data_t   s_ld_data;
    logic    s_ld_ma;
    logic    s_ld_ill;
    sel_t    s_st_sel;
    data_t   s_st_wdata;
    logic    s_st_ma;
    logic    s_st_ill;
    logic    s_ma;
    logic    s_ill;
    logic    s_accept;

    // Muxes see the live request while idle, the held one afterwards.
    assign s_func3  = (r_state == ST_IDLE) ? i_req_func3 : r_func3;
    assign s_offset = (r_state == ST_IDLE) ? offset_t'(i_req_addr[2:0]) : r_offset;

    load_mux u_load_mux (
        .i_func_3        (s_func3),
        .i_data          (i_wb_dat),
        .i_addr_offset   (s_offset),
        .o_data          (s_ld_data),
        .o_load_addr_ma  (s_ld_ma),
        .o_illegal_instr (s_ld_ill)
    );

    store_merge u_store_merge (
        .i_func_3        (s_func3),
        .i_wdata         (i_req_wdata),
        .i_addr_offset   (s_offset),
        .o_sel           (s_st_sel),
        .o_wdata         (s_st_wdata),
        .o_store_addr_ma (s_st_ma),
        .o_illegal_instr (s_st_ill)
    );

    assign s_ma     = i_req_we ? s_st_ma  : s_ld_ma;
    assign s_ill    = i_req_we ? s_st_ill : s_ld_ill;
    assign s_accept = i_req_valid && (r_state == ST_IDLE);

    // --------------------------------------------------
    // State machine.
    // --------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state <= ST_IDLE;
        end else begin
            case (r_state)
                ST_IDLE: begin
                    if (i_req_valid) begin
                        r_state <= (s_ma || s_ill) ? ST_RESP : ST_BUS;  // Faults skip the bus.
                    end
                end
                ST_BUS: begin
                    if (i_wb_ack) begin
                        r_state <= ST_RESP;
                    end
                end
                default: r_state <= ST_IDLE;
            endcase
        end
    end

    // Request capture and load data.
    always_ff @(posedge i_clk) begin
        if (s_accept) begin
            r_we         <= i_req_we;
            r_func3      <= i_req_func3;
            r_offset     <= i_req_addr[2:0];
            r_adr        <= i_req_addr[ADDR_WIDTH-1:3];
            r_sel        <= s_st_sel;
            r_wdata      <= s_st_wdata;
            r_misaligned <= s_ma;
            r_illegal    <= s_ill;
            r_rdata      <= '0;
        end else if ((r_state == ST_BUS) && i_wb_ack && !r_we) begin
            r_rdata <= s_ld_data;  // Extended at ack.
        end
    end

    assign o_req_ready      = (r_state == ST_IDLE);
    assign o_rsp_valid      = (r_state == ST_RESP);
    assign o_rsp_rdata      = r_rdata;
    assign o_rsp_misaligned = r_misaligned;
    assign o_rsp_illegal    = r_illegal;

    assign o_wb_cyc = (r_state == ST_BUS);
    assign o_wb_stb = (r_state == ST_BUS);  // Single transfer per cycle.
    assign o_wb_we  = r_we;
    assign o_wb_adr = r_adr;
    assign o_wb_sel = r_sel;
    assign o_wb_dat = r_wdata;

endmodule

// File: source/wb_arbiter.sv
/*
 * Round-robin Wishbone classic arbiter, two masters onto one slave.
 * Grant is registered and held for as long as the owner keeps cyc.
 */

`timescale 1ns/1ns

module wb_arbiter #(
    parameter int ADDR_WIDTH = 11
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // Master 0.
    input  logic                  i_m0_cyc,
    input  logic                  i_m0_stb,
    input  logic                  i_m0_we,
    input  logic [ADDR_WIDTH-4:0] i_m0_adr,
    input  lsu_pkg::sel_t         i_m0_sel,
    input  lsu_pkg::data_t        i_m0_dat,
    output logic                  o_m0_ack,
    output lsu_pkg::data_t        o_m0_dat,

    // Master 1.
    input  logic                  i_m1_cyc,
    input  logic                  i_m1_stb,
    input  logic                  i_m1_we,
    input  logic [ADDR_WIDTH-4:0] i_m1_adr,
    input  lsu_pkg::sel_t         i_m1_sel,
    input  lsu_pkg::data_t        i_m1_dat,
    output logic                  o_m1_ack,
    output lsu_pkg::data_t        o_m1_dat,

    // Slave.
    output logic                  o_s_cyc,
    output logic                  o_s_stb,
    output logic                  o_s_we,
    output logic [ADDR_WIDTH-4:0] o_s_adr,
    output lsu_pkg::sel_t         o_s_sel,
    output lsu_pkg::data_t        o_s_dat,
    input  logic                  i_s_ack,
    input  lsu_pkg::data_t        i_s_dat
);

    logic [1:0] r_gnt;   // One-hot, zero when the bus is idle.
    logic       r_last;  // Index of the master served last.
    logic       s_owner_cyc;

    assign s_owner_cyc = (r_gnt[0] && i_m0_cyc) || (r_gnt[1] && i_m1_cyc);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_gnt  <= 2'b00;
            r_last <= 1'b1;  // Master 0 wins the first tie.
        end else if (r_gnt == 2'b00) begin
            if (i_m0_cyc && (!i_m1_cyc || r_last)) begin
                r_gnt  <= 2'b01;
                r_last <= 1'b0;
            end else if (i_m1_cyc) begin
                r_gnt  <= 2'b10;
                r_last <= 1'b1;
            end
        end else if (!s_owner_cyc) begin
            r_gnt <= 2'b00;  // Owner finished.
        end
    end

    // --------------------------------------------------
    // Slave side mux.
    // --------------------------------------------------
    assign o_s_cyc = s_owner_cyc;
    assign o_s_stb = (r_gnt[0] && i_m0_stb) || (r_gnt[1] && i_m1_stb);
    assign o_s_we  = r_gnt[1] ? i_m1_we  : i_m0_we;
    assign o_s_adr = r_gnt[1] ? i_m1_adr : i_m0_adr;
    assign o_s_sel = r_gnt[1] ? i_m1_sel : i_m0_sel;
    assign o_s_dat = r_gnt[1] ? i_m1_dat : i_m0_dat;

    // Ack to the owner only. Read data is shared.
    assign o_m0_ack = r_gnt[0] && i_s_ack;
    assign o_m1_ack = r_gnt[1] && i_s_ack;
    assign o_m0_dat = i_s_dat;
    assign o_m1_dat = i_s_dat;

endmodule

// File: source/data_ram.sv
/*
 * Wishbone classic slave RAM of 64-bit words with byte-select writes.
 * Ack and read data come one clock after the cycle starts.
 */

`timescale 1ns/1ns

module data_ram #(
    parameter int ADDR_WIDTH = 11
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  logic [ADDR_WIDTH-4:0] i_wb_adr,
    input  lsu_pkg::sel_t         i_wb_sel,
    input  lsu_pkg::data_t        i_wb_dat,
    output logic                  o_wb_ack,
    output lsu_pkg::data_t        o_wb_dat
);
    import lsu_pkg::*;

    localparam int WORDS = 2 ** (ADDR_WIDTH - 3);

    data_t mem [0:WORDS-1];
    logic  s_start;

    assign s_start = i_wb_cyc && i_wb_stb && !o_wb_ack;  // New transfer.

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= s_start;
        end
    end

    always_ff @(posedge i_clk) begin
        if (s_start) begin
            if (i_wb_we) begin
                for (int i = 0; i < 8; i++) begin
                    if (i_wb_sel[i]) begin
                        mem[i_wb_adr][8*i +: 8] <= i_wb_dat[8*i +: 8];
                    end
                end
            end
            o_wb_dat <= mem[i_wb_adr];  // Old word on a write.
        end
    end

endmodule

// File: source/lsu_top.sv
/*
 * Data memory subsystem top. Two load/store ports share one RAM
 * through the round-robin Wishbone arbiter.
 */

`timescale 1ns/1ns

module lsu_top #(
    parameter int ADDR_WIDTH = 11
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // Port a.
    input  logic                  i_a_req_valid,
    output logic                  o_a_req_ready,
    input  logic                  i_a_req_we,
    input  lsu_pkg::func3_t       i_a_req_func3,
    input  logic [ADDR_WIDTH-1:0] i_a_req_addr,
    input  lsu_pkg::data_t        i_a_req_wdata,
    output logic                  o_a_rsp_valid,
    output lsu_pkg::data_t        o_a_rsp_rdata,
    output logic                  o_a_rsp_misaligned,
    output logic                  o_a_rsp_illegal,

    // Port b.
    input  logic                  i_b_req_valid,
    output logic                  o_b_req_ready,
    input  logic                  i_b_req_we,
    input  lsu_pkg::func3_t       i_b_req_func3,
    input  logic [ADDR_WIDTH-1:0] i_b_req_addr,
    input  lsu_pkg::data_t        i_b_req_wdata,
    output logic                  o_b_rsp_valid,
    output lsu_pkg::data_t        o_b_rsp_rdata,
    output logic                  o_b_rsp_misaligned,
    output logic                  o_b_rsp_illegal
);
    import lsu_pkg::*;

    // --------------------------------------------------
    // Bus wires. Port a is master 0, port b master 1.
    // --------------------------------------------------
    logic                  m0_cyc, m1_cyc, s_cyc;
    logic                  m0_stb, m1_stb, s_stb;
    logic                  m0_we,  m1_we,  s_we;
    logic [ADDR_WIDTH-4:0] m0_adr, m1_adr, s_adr;
    sel_t                  m0_sel, m1_sel, s_sel;
    data_t                 m0_dat_w, m1_dat_w, s_dat_w;
    logic                  m0_ack, m1_ack, s_ack;
    data_t                 m0_dat_r, m1_dat_r, s_dat_r;

    lsu_port #(.ADDR_WIDTH(ADDR_WIDTH)) u_port_a (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_req_valid      (i_a_req_valid),
        .o_req_ready      (o_a_req_ready),
        .i_req_we         (i_a_req_we),
        .i_req_func3      (i_a_req_func3),
        .i_req_addr       (i_a_req_addr),
        .i_req_wdata      (i_a_req_wdata),
        .o_rsp_valid      (o_a_rsp_valid),
        .o_rsp_rdata      (o_a_rsp_rdata),
        .o_rsp_misaligned (o_a_rsp_misaligned),
        .o_rsp_illegal    (o_a_rsp_illegal),
        .o_wb_cyc         (m0_cyc),
        .o_wb_stb         (m0_stb),
        .o_wb_we          (m0_we),
        .o_wb_adr         (m0_adr),
        .o_wb_sel         (m0_sel),
        .o_wb_dat         (m0_dat_w),
        .i_wb_ack         (m0_ack),
        .i_wb_dat         (m0_dat_r)
    );

    lsu_port #(.ADDR_WIDTH(ADDR_WIDTH)) u_port_b (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_req_valid      (i_b_req_valid),
        .o_req_ready      (o_b_req_ready),
        .i_req_we         (i_b_req_we),
        .i_req_func3      (i_b_req_func3),
        .i_req_addr       (i_b_req_addr),
        .i_req_wdata      (i_b_req_wdata),
        .o_rsp_valid      (o_b_rsp_valid),
        .o_rsp_rdata      (o_b_rsp_rdata),
        .o_rsp_misaligned (o_b_rsp_misaligned),
        .o_rsp_illegal    (o_b_rsp_illegal),
        .o_wb_cyc         (m1_cyc),
        .o_wb_stb         (m1_stb),
        .o_wb_we          (m1_we),
        .o_wb_adr         (m1_adr),
        .o_wb_sel         (m1_sel),
        .o_wb_dat         (m1_dat_w),
        .i_wb_ack         (m1_ack),
        .i_wb_dat         (m1_dat_r)
    );

    wb_arbiter #(.ADDR_WIDTH(ADDR_WIDTH)) u_arbiter (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_m0_cyc (m0_cyc),
        .i_m0_stb (m0_stb),
        .i_m0_we  (m0_we),
        .i_m0_adr (m0_adr),
        .i_m0_sel (m0_sel),
        .i_m0_dat (m0_dat_w),
        .o_m0_ack (m0_ack),
        .o_m0_dat (m0_dat_r),
        .i_m1_cyc (m1_cyc),
        .i_m1_stb (m1_stb),
        .i_m1_we  (m1_we),
        .i_m1_adr (m1_adr),
        .i_m1_sel (m1_sel),
        .i_m1_dat (m1_dat_w),
        .o_m1_ack (m1_ack),
        .o_m1_dat (m1_dat_r),
        .o_s_cyc  (s_cyc),
        .o_s_stb  (s_stb),
        .o_s_we   (s_we),
        .o_s_adr  (s_adr),
        .o_s_sel  (s_sel),
        .o_s_dat  (s_dat_w),
        .i_s_ack  (s_ack),
        .i_s_dat  (s_dat_r)
    );

    data_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_ram (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_wb_cyc (s_cyc),
        .i_wb_stb (s_stb),
        .i_wb_we  (s_we),
        .i_wb_adr (s_adr),
        .i_wb_sel (s_sel),
        .i_wb_dat (s_dat_w),
        .o_wb_ack (s_ack),
        .o_wb_dat (s_dat_r)
    );

endmodule

// File: test/lsu_props.sv
/*
 * Protocol assertions for the shared Wishbone bus and both request
 * ports. Bound into the subsystem top.
 */

`timescale 1ns/1ns

module lsu_props (
    input logic       i_clk,
    input logic       i_rst_n,
    input logic [1:0] i_gnt,
    input logic       i_s_cyc,
    input logic       i_s_stb,
    input logic       i_s_ack,
    input logic       i_a_cyc,
    input logic       i_b_cyc,
    input logic       i_a_rsp_valid,
    input logic       i_b_rsp_valid,
    input logic       i_a_req_ready,
    input logic       i_b_req_ready
);

    // Every slave ack belongs to exactly one granted master still in its cycle.
    a_one_grant: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_s_ack |-> (((i_gnt == 2'b01) && i_a_cyc) || ((i_gnt == 2'b10) && i_b_cyc)))
        else $error("ack not owned by a single granted master");

    // Slave ack only inside a live cycle.
    a_ack_in_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_s_ack |-> (i_s_cyc && i_s_stb))
        else $error("ack without cyc and stb");

    a_rsp_pulse_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_a_rsp_valid |=> !i_a_rsp_valid)
        else $error("port a response longer than one cycle");

    a_rsp_pulse_b: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_b_rsp_valid |=> !i_b_rsp_valid)
        else $error("port b response longer than one cycle");

    // --------------------------------------------------
    // Busy ports take no request.
    // --------------------------------------------------
    a_busy_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!i_a_req_ready && !i_a_rsp_valid) |=> !i_a_req_ready)
        else $error("port a ready before its response");

    a_busy_b: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!i_b_req_ready && !i_b_rsp_valid) |=> !i_b_req_ready)
        else $error("port b ready before its response");

endmodule

bind lsu_top lsu_props u_props (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_gnt         (u_arbiter.r_gnt),
    .i_s_cyc       (s_cyc),
    .i_s_stb       (s_stb),
    .i_s_ack       (s_ack),
    .i_a_cyc       (m0_cyc),
    .i_b_cyc       (m1_cyc),
    .i_a_rsp_valid (o_a_rsp_valid),
    .i_b_rsp_valid (o_b_rsp_valid),
    .i_a_req_ready (o_a_req_ready),
    .i_b_req_ready (o_b_req_ready)
);

// File: test/lsu_tb.sv
/*
 * Testbench for the two-port load/store subsystem. Both ports run in
 * parallel on xorshift stimulus, each on its own half of the RAM, and
 * every response is checked against a byte-level memory model.
 */

`timescale 1ns/1ns

module lsu_tb;
    import lsu_pkg::*;

    localparam int ADDR_WIDTH = 11;
    localparam int TIMEOUT    = 50;   // Cycles per wait.
    localparam int RAND_OPS   = 150;  // Per port.

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid [2];
    logic                  req_ready [2];
    logic                  req_we    [2];
    func3_t                req_func3 [2];
    logic [ADDR_WIDTH-1:0] req_addr  [2];
    data_t                 req_wdata [2];
    logic                  rsp_valid [2];
    data_t                 rsp_rdata [2];
    logic                  rsp_ma    [2];
    logic                  rsp_ill   [2];

    logic [7:0]  model_mem [0:2**ADDR_WIDTH-1];
    logic [31:0] rng [2];
    int          err_count;
    int          timeout_count;
    int          issued [2];
    int          rsp_count [2];

    lsu_top #(.ADDR_WIDTH(ADDR_WIDTH)) uut (
        .i_clk              (clk),
        .i_rst_n            (rst_n),
        .i_a_req_valid      (req_valid[0]),
        .o_a_req_ready      (req_ready[0]),
        .i_a_req_we         (req_we[0]),
        .i_a_req_func3      (req_func3[0]),
        .i_a_req_addr       (req_addr[0]),
        .i_a_req_wdata      (req_wdata[0]),
        .o_a_rsp_valid      (rsp_valid[0]),
        .o_a_rsp_rdata      (rsp_rdata[0]),
        .o_a_rsp_misaligned (rsp_ma[0]),
        .o_a_rsp_illegal    (rsp_ill[0]),
        .i_b_req_valid      (req_valid[1]),
        .o_b_req_ready      (req_ready[1]),
        .i_b_req_we         (req_we[1]),
        .i_b_req_func3      (req_func3[1]),
        .i_b_req_addr       (req_addr[1]),
        .i_b_req_wdata      (req_wdata[1]),
        .o_b_rsp_valid      (rsp_valid[1]),
        .o_b_rsp_rdata      (rsp_rdata[1]),
        .o_b_rsp_misaligned (rsp_ma[1]),
        .o_b_rsp_illegal    (rsp_ill[1])
    );

    always #20 clk = ~clk;

    // Response pulses per port, sampled mid-cycle.
    always @(negedge clk) begin
        if (rst_n) begin
            for (int p = 0; p < 2; p++) begin
                if (rsp_valid[p]) begin
                    rsp_count[p]++;
                end
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand(input int p);
        rng[p] = xorshift(rng[p]);
        return rng[p];
    endfunction

    // --------------------------------------------------
    // Memory model and expected responses.
    // --------------------------------------------------
    function automatic int width_bytes(input func3_t f3);
        return 1 << f3[1:0];
    endfunction

    function automatic offset_t align(input offset_t off, input func3_t f3);
        return off & offset_t'(~(width_bytes(f3) - 1));
    endfunction

    function automatic logic expect_illegal(input logic we, input func3_t f3);
        return we ? f3[2] : (f3 == 3'd7);
    endfunction

    function automatic logic expect_misaligned(input logic we, input func3_t f3,
                                               input logic [ADDR_WIDTH-1:0] addr);
        if (expect_illegal(we, f3)) begin
            return 1'b0;
        end
        return (int'(addr) % width_bytes(f3)) != 0;
    endfunction

    function automatic data_t model_load(input func3_t f3, input logic [ADDR_WIDTH-1:0] addr);
        data_t v;
        int    n;
        n = width_bytes(f3);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = model_mem[int'(addr) + i];
        end
        if (!f3[2] && n < 8 && v[8*n-1]) begin
            v = v | (~64'd0 << (8*n));  // Signed kinds.
        end
        return v;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] port_addr(input int p, input logic [6:0] word,
                                                        input offset_t off);
        return {p[0], word, off};  // Port b owns the upper half.
    endfunction

    task automatic do_op(input int p, input logic we, input func3_t f3,
                         input logic [ADDR_WIDTH-1:0] addr, input data_t wdata);
        int    n;
        logic  exp_ma;
        logic  exp_ill;
        data_t exp_data;

        exp_ill  = expect_illegal(we, f3);
        exp_ma   = expect_misaligned(we, f3, addr);
        exp_data = (exp_ill || exp_ma) ? '0 : model_load(f3, addr);
        req_valid[p] = 1'b1;
        req_we[p]    = we;
        req_func3[p] = f3;
        req_addr[p]  = addr;
        req_wdata[p] = wdata;
        n = 0;
        while (!req_ready[p] && n < TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!req_ready[p]) begin
            $display("port %0d timed out waiting for request ready", p);
            timeout_count++;
            req_valid[p] = 1'b0;
            return;
        end
        @(posedge clk);  // Transfer edge.
        #2;
        req_valid[p] = 1'b0;
        issued[p]++;
        n = 0;
        while (!rsp_valid[p] && n < TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!rsp_valid[p]) begin
            $display("port %0d timed out waiting for a response", p);
            timeout_count++;
            return;
        end
        if (rsp_ma[p] !== exp_ma || rsp_ill[p] !== exp_ill) begin
            $display("error %0t: port %0d we=%0b f3=%0d addr=%h flags ma=%b ill=%b, expected %b %b",
                     $time, p, we, f3, addr, rsp_ma[p], rsp_ill[p], exp_ma, exp_ill);
            err_count++;
        end
        if (!we && rsp_rdata[p] !== exp_data) begin
            $display("error %0t: port %0d f3=%0d addr=%h load data %h, expected %h",
                     $time, p, f3, addr, rsp_rdata[p], exp_data);
            err_count++;
        end
        if (we && !exp_ill && !exp_ma) begin
            for (int i = 0; i < width_bytes(f3); i++) begin
                model_mem[int'(addr) + i] = wdata[8*i +: 8];
            end
        end
    endtask

    task automatic run_port(input int p);
        logic [31:0] r;
        logic [6:0]  word;
        func3_t      f3;
        offset_t     off;

        // Known contents for the whole half first.
        for (int w = 0; w < 128; w++) begin
            do_op(p, 1'b1, F3_LD, port_addr(p, 7'(w), 3'd0), {next_rand(p), next_rand(p)});
        end
        for (int s = 0; s < 4; s++) begin
            r    = next_rand(p);
            word = r[6:0];
            off  = align(r[9:7], func3_t'(s));
            do_op(p, 1'b1, func3_t'(s), port_addr(p, word, off), {next_rand(p), next_rand(p)});
            for (int l = 0; l < 7; l++) begin  // Every load kind on every lane.
                for (int o = 0; o < 8; o += width_bytes(func3_t'(l))) begin
                    do_op(p, 1'b0, func3_t'(l), port_addr(p, word, offset_t'(o)), '0);
                end
            end
        end
        r    = next_rand(p);
        word = r[6:0];
        for (int s = 1; s < 4; s++) begin
            for (int o = 1; o < 8; o++) begin
                if ((o % width_bytes(func3_t'(s))) != 0) begin
                    do_op(p, 1'b1, func3_t'(s), port_addr(p, word, offset_t'(o)),
                          {next_rand(p), next_rand(p)});
                    do_op(p, 1'b0, func3_t'(s), port_addr(p, word, offset_t'(o)), '0);
                end
            end
        end
        do_op(p, 1'b0, F3_LD, port_addr(p, word, 3'd0), '0);
        // Illegal codes.
        do_op(p, 1'b0, 3'd7, port_addr(p, word, 3'd0), '0);
        for (int c = 4; c < 8; c++) begin
            do_op(p, 1'b1, func3_t'(c), port_addr(p, word, 3'd0), {next_rand(p), next_rand(p)});
        end
        do_op(p, 1'b0, F3_LD, port_addr(p, word, 3'd0), '0);
        for (int k = 0; k < RAND_OPS; k++) begin
            r   = next_rand(p);
            f3  = r[3:1];
            off = r[8:6];
            if (r[10:9] != 2'b00) begin
                off = align(off, f3);  // Mostly aligned.
            end
            do_op(p, r[0], f3, port_addr(p, r[17:11], off), {next_rand(p), next_rand(p)});
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        err_count     = 0;
        timeout_count = 0;
        rng[0]        = 32'hff9f;
        rng[1]        = xorshift(32'hff9f);
        for (int p = 0; p < 2; p++) begin
            req_valid[p] = 1'b0;
            req_we[p]    = 1'b0;
            req_func3[p] = '0;
            req_addr[p]  = '0;
            req_wdata[p] = '0;
            issued[p]    = 0;
            rsp_count[p] = 0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #2;
            for (int p = 0; p < 2; p++) begin
                if (!req_ready[p] || rsp_valid[p]) begin
                    $display("error %0t: port %0d not idle after reset", $time, p);
                    err_count++;
                end
            end
        end
        fork
            run_port(0);
            run_port(1);
        join
        repeat (2) @(posedge clk);
        for (int p = 0; p < 2; p++) begin
            if (rsp_count[p] != issued[p]) begin
                $display("port %0d gave %0d responses for %0d requests", p, rsp_count[p], issued[p]);
                err_count++;
            end
        end
        $display("errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
source/lsu_pkg.sv
source/load_mux.sv
source/store_merge.sv
source/lsu_port.sv
source/wb_arbiter.sv
source/data_ram.sv
source/lsu_top.sv
test/lsu_props.sv
test/lsu_tb.sv

// File: Makefile
TOP = lsu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o sim_$(TOP)
	out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
